// File: hdl/riscv_core.sv
////////////////////////////////////////////////////////////////////////////
// Core top level: fetch, decode, execute, memory/write-back
// and the integer register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_core
  import riscv_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,

  // Instruction bus
  output word_t      iwb_adr_o,
  output logic       iwb_cyc_o,
  output logic       iwb_stb_o,
  input  word_t      iwb_dat_i,
  input  logic       iwb_ack_i,

  // Data bus, write only
  output word_t      dwb_adr_o,
  output word_t      dwb_dat_o,
  output logic [3:0] dwb_sel_o,
  output logic       dwb_cyc_o,
  output logic       dwb_stb_o,
  input  logic       dwb_ack_i
);

  if_id_t   if_id;
  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  fwd_t     ex_fwd;
  fwd_t     wb_fwd;
  logic     id_stall;
  logic     ex_stall;
  logic     mem_stall;
  reg_idx_t rf_rs1;
  reg_idx_t rf_rs2;
  word_t    rf_rd1;
  word_t    rf_rd2;

  riscv_if if_unit (
    .clk_i      ( clk_i     ),
    .rst_i      ( rst_i     ),
    .iwb_adr_o  ( iwb_adr_o ),
    .iwb_cyc_o  ( iwb_cyc_o ),
    .iwb_stb_o  ( iwb_stb_o ),
    .iwb_dat_i  ( iwb_dat_i ),
    .iwb_ack_i  ( iwb_ack_i ),
    .id_stall_i ( id_stall  ),
    .if_id_o    ( if_id     ) );

  riscv_id id_unit (
    .clk_i      ( clk_i    ),
    .rst_i      ( rst_i    ),
    .if_id_i    ( if_id    ),
    .ex_stall_i ( ex_stall ),
    .id_stall_o ( id_stall ),
    .rf_rs1_o   ( rf_rs1   ),
    .rf_rs2_o   ( rf_rs2   ),
    .rf_rd1_i   ( rf_rd1   ),
    .rf_rd2_i   ( rf_rd2   ),
    .ex_fwd_i   ( ex_fwd   ),
    .wb_fwd_i   ( wb_fwd   ),
    .id_ex_o    ( id_ex    ) );

  riscv_rf int_rf (
    .clk_i    ( clk_i  ),
    .rs1_i    ( rf_rs1 ),
    .rs2_i    ( rf_rs2 ),
    .rd1_o    ( rf_rd1 ),
    .rd2_o    ( rf_rd2 ),
    .wb_fwd_i ( wb_fwd ) );

  riscv_ex ex_unit (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .id_ex_i     ( id_ex     ),
    .mem_stall_i ( mem_stall ),
    .ex_stall_o  ( ex_stall  ),
    .ex_fwd_o    ( ex_fwd    ),
    .ex_mem_o    ( ex_mem    ) );

  riscv_mem mem_unit (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .ex_mem_i    ( ex_mem    ),
    .dwb_adr_o   ( dwb_adr_o ),
    .dwb_dat_o   ( dwb_dat_o ),
    .dwb_sel_o   ( dwb_sel_o ),
    .dwb_cyc_o   ( dwb_cyc_o ),
    .dwb_stb_o   ( dwb_stb_o ),
    .dwb_ack_i   ( dwb_ack_i ),
    .mem_stall_o ( mem_stall ),
    .wb_fwd_o    ( wb_fwd    ) );

endmodule

`default_nettype wire

// File: hdl/riscv_ex.sv
////////////////////////////////////////////////////////////////////////////
// Execute: ALU, store lane/byte-select preparation
// and the execute/memory register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_ex
  import riscv_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  id_ex_t  id_ex_i,
  input  logic    mem_stall_i,
  output logic    ex_stall_o,
  output fwd_t    ex_fwd_o,
  output ex_mem_t ex_mem_o
);

  word_t      alu_r;
  logic [1:0] lane;
  ex_mem_t    ex_mem_d;
  ex_mem_t    ex_mem_q;

  always_comb
  begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_r = id_ex_i.opA + id_ex_i.opB;
      ALU_SUB:    alu_r = id_ex_i.opA - id_ex_i.opB;
      ALU_AND:    alu_r = id_ex_i.opA & id_ex_i.opB;
      ALU_OR:     alu_r = id_ex_i.opA | id_ex_i.opB;
      ALU_XOR:    alu_r = id_ex_i.opA ^ id_ex_i.opB;
      ALU_PASS_B: alu_r = id_ex_i.opB;
      default:    alu_r = '0;
    endcase
  end

  assign lane = alu_r[1:0];

  always_comb
  begin
    ex_mem_d.valid    = id_ex_i.valid;
    ex_mem_d.result   = alu_r;
    ex_mem_d.is_store = id_ex_i.is_store;
    ex_mem_d.rd       = id_ex_i.rd;
    ex_mem_d.we       = id_ex_i.we;
    if (id_ex_i.is_byte)
    begin
      ex_mem_d.wdata = word_t'(id_ex_i.store_data[7:0]) << {lane, 3'b000};
      ex_mem_d.sel   = 4'b0001 << lane;
    end
    else
    begin
      ex_mem_d.wdata = id_ex_i.store_data;
      ex_mem_d.sel   = 4'b1111;
      if (id_ex_i.is_store)
        ex_mem_d.result = {alu_r[XLEN-1:2], 2'b00};   // Word aligned
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ex_mem_q.valid    <= 1'b0;
      ex_mem_q.we       <= 1'b0;
      ex_mem_q.is_store <= 1'b0;
    end
    else if (!mem_stall_i)
      ex_mem_q <= ex_mem_d;
  end

  // Result of the instruction now in execute, for decode
  assign ex_fwd_o   = {id_ex_i.valid & id_ex_i.we, id_ex_i.rd, alu_r};
  assign ex_stall_o = mem_stall_i;
  assign ex_mem_o   = ex_mem_q;

endmodule

`default_nettype wire

// File: hdl/riscv_id.sv
////////////////////////////////////////////////////////////////////////////
// Instruction decode for the RV32I subset
// Immediate generation, operand forwarding, decode/execute register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_id
  import riscv_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  if_id_t   if_id_i,
  input  logic     ex_stall_i,
  output logic     id_stall_o,
  output reg_idx_t rf_rs1_o,
  output reg_idx_t rf_rs2_o,
  input  word_t    rf_rd1_i,
  input  word_t    rf_rd2_i,
  input  fwd_t     ex_fwd_i,
  input  fwd_t     wb_fwd_i,
  output id_ex_t   id_ex_o
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  word_t      rs1_val;
  word_t      rs2_val;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;
  logic       legal;
  id_ex_t     id_ex_d;
  id_ex_t     id_ex_q;

  // Youngest producer wins, x0 never forwarded
  function automatic word_t fwd_pick(reg_idx_t idx, word_t rf_val, fwd_t ex_f, fwd_t wb_f);
    word_t val;
    val = rf_val;
    if (idx != '0 && wb_f.we && wb_f.rd == idx)
      val = wb_f.value;
    if (idx != '0 && ex_f.we && ex_f.rd == idx)
      val = ex_f.value;
    return val;
  endfunction

  assign opcode   = if_id_i.insn[6:0];
  assign funct3   = if_id_i.insn[14:12];
  assign funct7   = if_id_i.insn[31:25];
  assign rd       = if_id_i.insn[11:7];
  assign rf_rs1_o = if_id_i.insn[19:15];
  assign rf_rs2_o = if_id_i.insn[24:20];

  assign imm_i = {{20{if_id_i.insn[31]}}, if_id_i.insn[31:20]};
  assign imm_s = {{20{if_id_i.insn[31]}}, if_id_i.insn[31:25], if_id_i.insn[11:7]};
  assign imm_u = {if_id_i.insn[31:12], 12'h000};

  assign rs1_val = fwd_pick(rf_rs1_o, rf_rd1_i, ex_fwd_i, wb_fwd_i);
  assign rs2_val = fwd_pick(rf_rs2_o, rf_rd2_i, ex_fwd_i, wb_fwd_i);

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  always_comb
  begin
    id_ex_d            = '0;
    id_ex_d.alu_op     = ALU_ADD;
    id_ex_d.opA        = rs1_val;
    id_ex_d.opB        = rs2_val;
    id_ex_d.store_data = rs2_val;
    id_ex_d.rd         = rd;
    legal              = 1'b1;

    case (opcode)
      OPC_OP, OPC_OP_IMM:
      begin
        id_ex_d.we = 1'b1;
        case (funct3)
          3'b000:  id_ex_d.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b100:  id_ex_d.alu_op = ALU_XOR;
          3'b110:  id_ex_d.alu_op = ALU_OR;
          3'b111:  id_ex_d.alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
        if (opcode == OPC_OP)
          legal = legal && (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b000));
        else
          id_ex_d.opB = imm_i;
      end
      OPC_LUI:
      begin
        id_ex_d.we     = 1'b1;
        id_ex_d.alu_op = ALU_PASS_B;
        id_ex_d.opB    = imm_u;
      end
      OPC_STORE:
      begin
        id_ex_d.is_store = 1'b1;
        id_ex_d.is_byte  = (funct3 == 3'b000);
        id_ex_d.opB      = imm_s;                  // Address = rs1 + imm
        legal            = (funct3 == 3'b000) || (funct3 == 3'b010);
      end
      default: legal = 1'b0;                      // Outside subset, bubble
    endcase

    id_ex_d.valid    = if_id_i.valid & legal;
    id_ex_d.we       = id_ex_d.we & id_ex_d.valid & (rd != '0);
    id_ex_d.is_store = id_ex_d.is_store & id_ex_d.valid;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      id_ex_q.valid    <= 1'b0;
      id_ex_q.we       <= 1'b0;
      id_ex_q.is_store <= 1'b0;
    end
    else if (!ex_stall_i)
      id_ex_q <= id_ex_d;
  end

  assign id_stall_o = ex_stall_i;
  assign id_ex_o    = id_ex_q;

endmodule

`default_nettype wire

// File: hdl/riscv_if.sv
////////////////////////////////////////////////////////////////////////////
// Instruction fetch: program counter, Wishbone fetch FSM
// and a one-entry skid buffer toward decode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_if
  import riscv_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  output word_t  iwb_adr_o,
  output logic   iwb_cyc_o,
  output logic   iwb_stb_o,
  input  word_t  iwb_dat_i,
  input  logic   iwb_ack_i,
  input  logic   id_stall_i,
  output if_id_t if_id_o
);

  fetch_state_e state_q;
  word_t        pc_q;
  if_id_t       out_q;
  if_id_t       skid_q;
  logic         take;

  assign iwb_adr_o = pc_q;
  assign iwb_cyc_o = (state_q == FETCH_REQ);
  assign iwb_stb_o = (state_q == FETCH_REQ);
  assign take      = iwb_cyc_o & iwb_ack_i;   // Word accepted this cycle
  assign if_id_o   = out_q;

  // Fetch FSM, one word per bus cycle
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q <= FETCH_HOLD;
      pc_q    <= PC_INIT;
    end
    else
    begin
      case (state_q)
        FETCH_REQ:
        begin
          if (take)
          begin
            state_q <= FETCH_HOLD;
            pc_q    <= pc_q + 32'd4;
          end
        end
        FETCH_HOLD:
        begin
          // No new request while the pipe is backed up
          if (!id_stall_i && !skid_q.valid)
            state_q <= FETCH_REQ;
        end
        default: state_q <= FETCH_HOLD;
      endcase
    end
  end

  // Output register and skid entry
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      out_q.valid  <= 1'b0;
      skid_q.valid <= 1'b0;
    end
    else if (!id_stall_i)
    begin
      if (take)
        out_q <= {1'b1, pc_q, iwb_dat_i};
      else if (skid_q.valid)
      begin
        out_q        <= skid_q;
        skid_q.valid <= 1'b0;
      end
      else
      begin
        out_q.valid <= 1'b0;                   // Bubble
        out_q.insn  <= NOP_INSN;
      end
    end
    else if (take)
      skid_q <= {1'b1, pc_q, iwb_dat_i};       // Park word until stall clears
  end

endmodule

`default_nettype wire

// File: hdl/riscv_mem.sv
////////////////////////////////////////////////////////////////////////////
// Memory/write-back: Wishbone store master
// and register file write port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_mem
  import riscv_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  ex_mem_t    ex_mem_i,
  output word_t      dwb_adr_o,
  output word_t      dwb_dat_o,
  output logic [3:0] dwb_sel_o,
  output logic       dwb_cyc_o,
  output logic       dwb_stb_o,
  input  logic       dwb_ack_i,
  output logic       mem_stall_o,
  output fwd_t       wb_fwd_o
);

  logic store_req;
  logic done;
  logic gap_q;   // cyc/stb low for one cycle after ack

  assign store_req = ex_mem_i.valid & ex_mem_i.is_store;
  assign done      = dwb_stb_o & dwb_ack_i;

  ////////////////////////////////////////////////////////////////////////////
  // Store bus cycle
  assign dwb_adr_o = ex_mem_i.result;
  assign dwb_dat_o = ex_mem_i.wdata;
  assign dwb_sel_o = ex_mem_i.sel;
  assign dwb_cyc_o = store_req & ~gap_q;
  assign dwb_stb_o = store_req & ~gap_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      gap_q <= 1'b0;
    else
      gap_q <= done;
  end

  // Hold the whole pipe until the slave acks
  assign mem_stall_o = store_req & ~done;

  // Write-back in the cycle the result lands here
  assign wb_fwd_o.we    = ex_mem_i.valid & ex_mem_i.we & ~ex_mem_i.is_store;
  assign wb_fwd_o.rd    = ex_mem_i.rd;
  assign wb_fwd_o.value = ex_mem_i.result;

endmodule

`default_nettype wire

// File: hdl/riscv_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Core-wide widths, opcodes and reset PC
// Stage structs, ALU and fetch enums
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package riscv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [6:0]      opcode_t;

  localparam word_t PC_INIT = 32'h200;

  // Major opcodes of the supported subset
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_STORE  = 7'b0100011;

  localparam word_t NOP_INSN = 32'h0000_0013;  // ADDI x0,x0,0

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic {
    FETCH_REQ,
    FETCH_HOLD
  } fetch_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Stage payloads
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t insn;
  } if_id_t;

  typedef struct packed {
    logic     valid;
    alu_op_e  alu_op;
    word_t    opA;
    word_t    opB;
    word_t    store_data;   // rs2 value for stores
    logic     is_store;
    logic     is_byte;      // SB, else SW
    reg_idx_t rd;
    logic     we;
  } id_ex_t;

  typedef struct packed {
    logic       valid;
    word_t      result;     // Also the store address
    word_t      wdata;      // Already in its byte lane
    logic [3:0] sel;
    logic       is_store;
    reg_idx_t   rd;
    logic       we;
  } ex_mem_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    value;
  } fwd_t;

endpackage

`default_nettype wire

// File: hdl/riscv_rf.sv
////////////////////////////////////////////////////////////////////////////
// Integer register file, 2 async reads, 1 clocked write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_rf
  import riscv_pkg::*;
(
  input  logic     clk_i,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  output word_t    rd1_o,
  output word_t    rd2_o,
  input  fwd_t     wb_fwd_i
);

  word_t regs [1:31];   // x0 has no storage

  always_ff @(posedge clk_i)
  begin
    if (wb_fwd_i.we && wb_fwd_i.rd != '0)
      regs[wb_fwd_i.rd] <= wb_fwd_i.value;
  end

  // x0 hardwired to zero
  assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: riscv_core.f
hdl/riscv_pkg.sv
hdl/riscv_if.sv
hdl/riscv_id.sv
hdl/riscv_rf.sv
hdl/riscv_ex.sv
hdl/riscv_mem.sv
hdl/riscv_core.sv
sim/riscv_core_tb.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module riscv_core_tb \
  -f riscv_core.f -o riscv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/riscv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: sim/riscv_core_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the four-stage core: clock, reset, Wishbone bus models
// Program and expected-store table, store checks, per-test reporting
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_core_tb
  import riscv_pkg::*;
();

  localparam int NUM_TESTS      = 6;
  localparam int PROG_WORDS     = 8;
  localparam int MAX_STORES     = 4;
  localparam int TEST_CYCLES    = 200;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES * NUM_TESTS;
  localparam int STORE_WAIT     = 120;   // Limit for the last expected store
  localparam int DRAIN_CYCLES   = 24;    // Quiet window that catches extra stores

  typedef struct packed {
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
  } store_t;

  logic       clk_i;
  logic       rst_i;
  word_t      iwb_adr_o;
  logic       iwb_cyc_o;
  logic       iwb_stb_o;
  word_t      iwb_dat_i;
  logic       iwb_ack_i;
  word_t      dwb_adr_o;
  word_t      dwb_dat_o;
  logic [3:0] dwb_sel_o;
  logic       dwb_cyc_o;
  logic       dwb_stb_o;
  logic       dwb_ack_i;

  // Test table
  string  test_name [NUM_TESTS];
  word_t  prog      [NUM_TESTS][PROG_WORDS];
  int     prog_len  [NUM_TESTS];
  store_t exp_st    [NUM_TESTS][MAX_STORES];
  int     exp_cnt   [NUM_TESTS];

  int          cur_test;
  int          st_seen;     // Stores acked in the current test
  int          test_err;
  int          err_cnt;
  int          pass_cnt;
  int          cycle_cnt;
  int          wait_cnt;
  logic        dwb_busy;
  logic [31:0] lcg_state;

  riscv_core dut_i (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .iwb_adr_o ( iwb_adr_o ),
    .iwb_cyc_o ( iwb_cyc_o ),
    .iwb_stb_o ( iwb_stb_o ),
    .iwb_dat_i ( iwb_dat_i ),
    .iwb_ack_i ( iwb_ack_i ),
    .dwb_adr_o ( dwb_adr_o ),
    .dwb_dat_o ( dwb_dat_o ),
    .dwb_sel_o ( dwb_sel_o ),
    .dwb_cyc_o ( dwb_cyc_o ),
    .dwb_stb_o ( dwb_stb_o ),
    .dwb_ack_i ( dwb_ack_i ) );

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoders
  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_i(logic [6:0] opc, logic [11:0] imm, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_lui(logic [19:0] imm, reg_idx_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Program word at a fetch address, NOP past the end
  function automatic word_t fetch_word(word_t adr);
    word_t idx;
    idx = (adr - PC_INIT) >> 2;
    if (adr >= PC_INIT && idx < word_t'(prog_len[cur_test]))
      return prog[cur_test][idx[2:0]];
    return NOP_INSN;
  endfunction

  task automatic add_word(int t, word_t w);
    prog[t][prog_len[t]] = w;
    prog_len[t]++;
  endtask

  task automatic add_store(int t, word_t adr, word_t dat, logic [3:0] sel);
    exp_st[t][exp_cnt[t]] = {adr, dat, sel};
    exp_cnt[t]++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Programs and expected stores
  task automatic build_table();
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      prog_len[t] = 0;
      exp_cnt[t]  = 0;
    end

    test_name[0] = "alu_imm";
    add_word(0, enc_i(7'h13, 12'h123, 5'd0, 3'b000, 5'd1));    // addi x1,x0,0x123
    add_word(0, enc_i(7'h13, 12'h0f0, 5'd1, 3'b110, 5'd2));    // ori x2,x1,0x0f0
    add_word(0, enc_i(7'h13, 12'h0f5, 5'd2, 3'b111, 5'd3));    // andi x3,x2,0x0f5
    add_word(0, enc_i(7'h13, 12'hfff, 5'd3, 3'b100, 5'd4));    // xori x4,x3,-1
    add_word(0, enc_s(12'h100, 5'd1, 5'd0, 3'b010));
    add_word(0, enc_s(12'h104, 5'd2, 5'd0, 3'b010));
    add_word(0, enc_s(12'h108, 5'd3, 5'd0, 3'b010));
    add_word(0, enc_s(12'h10c, 5'd4, 5'd0, 3'b010));
    add_store(0, 32'h100, 32'h0000_0123, 4'b1111);
    add_store(0, 32'h104, 32'h0000_01f3, 4'b1111);
    add_store(0, 32'h108, 32'h0000_00f1, 4'b1111);
    add_store(0, 32'h10c, 32'hffff_ff0e, 4'b1111);

    // Each op consumes the previous result
    test_name[1] = "alu_reg_chain";
    add_word(1, enc_i(7'h13, 12'h5a5, 5'd0, 3'b000, 5'd1));
    add_word(1, enc_i(7'h13, 12'h0f3, 5'd0, 3'b000, 5'd2));
    add_word(1, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));       // add x3 = 0x698
    add_word(1, enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));       // sub x4 = 0x5a5
    add_word(1, enc_r(7'h00, 5'd3, 5'd4, 3'b111, 5'd5));       // and x5 = 0x480
    add_word(1, enc_r(7'h00, 5'd2, 5'd5, 3'b110, 5'd6));       // or x6 = 0x4f3
    add_word(1, enc_r(7'h00, 5'd5, 5'd6, 3'b100, 5'd7));       // xor x7 = 0x073
    add_word(1, enc_s(12'h140, 5'd7, 5'd0, 3'b010));
    add_store(1, 32'h140, 32'h0000_0073, 4'b1111);

    test_name[2] = "lui_addi";
    add_word(2, enc_lui(20'h12345, 5'd8));
    add_word(2, enc_i(7'h13, 12'h678, 5'd8, 3'b000, 5'd8));
    add_word(2, enc_lui(20'hdeadc, 5'd9));
    add_word(2, enc_i(7'h13, 12'heef, 5'd9, 3'b000, 5'd9));    // Negative imm -0x111
    add_word(2, enc_s(12'h180, 5'd8, 5'd0, 3'b010));
    add_word(2, enc_s(12'h184, 5'd9, 5'd0, 3'b010));
    add_store(2, 32'h180, 32'h1234_5678, 4'b1111);
    add_store(2, 32'h184, 32'hdead_beef, 4'b1111);

    test_name[3] = "sb_lanes";
    add_word(3, enc_i(7'h13, 12'h7c3, 5'd0, 3'b000, 5'd10));
    add_word(3, enc_i(7'h13, 12'h300, 5'd0, 3'b000, 5'd11));
    add_word(3, enc_s(12'h000, 5'd10, 5'd11, 3'b000));
    add_word(3, enc_s(12'h001, 5'd10, 5'd11, 3'b000));
    add_word(3, enc_s(12'h002, 5'd10, 5'd11, 3'b000));
    add_word(3, enc_s(12'h003, 5'd10, 5'd11, 3'b000));
    add_store(3, 32'h300, 32'h0000_00c3, 4'b0001);
    add_store(3, 32'h301, 32'h0000_c300, 4'b0010);
    add_store(3, 32'h302, 32'h00c3_0000, 4'b0100);
    add_store(3, 32'h303, 32'hc300_0000, 4'b1000);

    test_name[4] = "x0_and_unsupported";
    add_word(4, enc_i(7'h13, 12'h055, 5'd0, 3'b000, 5'd0));    // Write to x0
    add_word(4, enc_s(12'h1c0, 5'd0, 5'd0, 3'b010));
    add_word(4, enc_i(7'h13, 12'h021, 5'd0, 3'b000, 5'd12));
    add_word(4, 32'h0000_067f);                                 // Unknown opcode, rd x12
    add_word(4, enc_i(7'h13, 12'h003, 5'd12, 3'b001, 5'd12));  // slli
    add_word(4, enc_i(7'h03, 12'h000, 5'd0, 3'b010, 5'd12));   // lw
    add_word(4, enc_s(12'h1c8, 5'd12, 5'd0, 3'b001));          // sh, must not store
    add_word(4, enc_s(12'h1c4, 5'd12, 5'd0, 3'b010));
    add_store(4, 32'h1c0, 32'h0000_0000, 4'b1111);
    add_store(4, 32'h1c4, 32'h0000_0021, 4'b1111);

    test_name[5] = "store_order";
    add_word(5, enc_i(7'h13, 12'h011, 5'd0, 3'b000, 5'd13));
    add_word(5, enc_i(7'h13, 12'hffe, 5'd0, 3'b000, 5'd14));   // -2
    add_word(5, enc_s(12'h3f0, 5'd13, 5'd0, 3'b010));
    add_word(5, enc_s(12'h3f4, 5'd14, 5'd0, 3'b010));
    add_word(5, enc_s(12'h3f9, 5'd13, 5'd0, 3'b000));
    add_word(5, enc_r(7'h00, 5'd14, 5'd13, 3'b000, 5'd15));
    add_word(5, enc_s(12'h3fc, 5'd15, 5'd0, 3'b010));
    add_store(5, 32'h3f0, 32'h0000_0011, 4'b1111);
    add_store(5, 32'h3f4, 32'hffff_fffe, 4'b1111);
    add_store(5, 32'h3f9, 32'h0000_1100, 4'b0010);
    add_store(5, 32'h3fc, 32'h0000_000f, 4'b1111);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus models
  task automatic check_store();
    store_t seen;
    store_t want;
    seen = {dwb_adr_o, dwb_dat_o, dwb_sel_o};
    assert (st_seen < exp_cnt[cur_test])
    else
    begin
      $display("%s: surplus store to address %h after all %0d expected stores",
               test_name[cur_test], dwb_adr_o, exp_cnt[cur_test]);
      test_err++;
    end
    if (st_seen < exp_cnt[cur_test])
    begin
      want = exp_st[cur_test][st_seen];
      assert (seen == want)
      else
      begin
        $display("MISMATCH %s store %0d: expected adr %h dat %h sel %b, actual adr %h dat %h sel %b",
                 test_name[cur_test], st_seen, want.adr, want.dat, want.sel,
                 seen.adr, seen.dat, seen.sel);
        test_err++;
      end
    end
    st_seen++;
  endtask

  // Instruction slave, one ack per request
  always @(posedge clk_i)
  begin
    #1;
    if (iwb_ack_i)
      iwb_ack_i = 1'b0;
    else if (iwb_cyc_o && iwb_stb_o)
    begin
      iwb_dat_i = fetch_word(iwb_adr_o);
      iwb_ack_i = 1'b1;
    end
  end

  // Data slave with 0 to 3 wait cycles
  always @(posedge clk_i)
  begin
    #1;
    if (dwb_ack_i)
      dwb_ack_i = 1'b0;
    else if (dwb_cyc_o && dwb_stb_o)
    begin
      if (!dwb_busy)
      begin
        dwb_busy = 1'b1;
        wait_cnt = int'(lcg_next() % 32'd4);
      end
      if (wait_cnt == 0)
      begin
        dwb_ack_i = 1'b1;
        dwb_busy  = 1'b0;
        check_store();
      end
      else
        wait_cnt--;
    end
    else
      dwb_busy = 1'b0;
  end

  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  task automatic run_test(int t);
    int waited;
    @(posedge clk_i);
    #1;
    rst_i = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    cur_test = t;
    st_seen  = 0;
    test_err = 0;
    rst_i    = 1'b0;
    waited   = 0;
    while (st_seen < exp_cnt[t] && waited < STORE_WAIT)
    begin
      @(posedge clk_i);
      waited++;
    end
    assert (st_seen >= exp_cnt[t])
    else
    begin
      $display("%s: missing stores, only %0d of %0d seen", test_name[t], st_seen,
               exp_cnt[t]);
      test_err++;
    end
    repeat (DRAIN_CYCLES) @(posedge clk_i);
    err_cnt += test_err;
    if (test_err == 0)
    begin
      pass_cnt++;
      $display("PASS %s", test_name[t]);
    end
    else
      $display("FAIL %s with %0d errors", test_name[t], test_err);
  endtask

  initial
  begin
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    iwb_dat_i = NOP_INSN;
    iwb_ack_i = 1'b0;
    dwb_ack_i = 1'b0;
    dwb_busy  = 1'b0;
    wait_cnt  = 0;
    lcg_state = 32'h6ad7;
    cur_test  = 0;
    st_seen   = 0;
    test_err  = 0;
    err_cnt   = 0;
    pass_cnt  = 0;
    cycle_cnt = 0;
    build_table();

    for (int t = 0; t < NUM_TESTS; t++)
    begin
      run_test(t);
    end

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d", NUM_TESTS, pass_cnt,
             NUM_TESTS - pass_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
